// ==== filelist.f ====
src/hdc_pkg.sv
src/bind_core.sv
src/dim_counter.sv
src/bundle_buffer.sv
src/apb_regs.sv
src/hdc_bundle_top.sv
sim/tb_hdc_bundle.sv

// ==== sim/tb_hdc_bundle.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hdc_bundle;

    localparam int TIMEOUT = 50;
    localparam int NROWS   = 7;
    // unmapped address for the slave error check
    localparam logic [hdc_pkg::APB_AW-1:0] ADDR_HOLE = 8'h20;

    // one row of the stimulus table
    typedef struct packed {
        logic [hdc_pkg::SHIFT_W-1:0]      shift;
        logic [hdc_pkg::DIM-1:0]          key;
        logic [7:0]                       cycles;
        logic [hdc_pkg::CORE_NUM-1:0]     mask;
        logic                             clr;
        logic [hdc_pkg::SAMPLE_CNT_W-1:0] count;
    } row_t;

    logic                                       clk;
    logic                                       rst_n;
    logic                                       psel;
    logic                                       penable;
    logic                                       pwrite;
    logic [hdc_pkg::APB_AW-1:0]                 paddr;
    logic [hdc_pkg::APB_DW-1:0]                 pwdata;
    logic [hdc_pkg::APB_DW-1:0]                 prdata;
    logic                                       pready;
    logic                                       pslverr;
    logic [hdc_pkg::CORE_NUM-1:0]               item_v;
    logic [hdc_pkg::CORE_NUM*hdc_pkg::DIM-1:0]  item_hv;
    logic                                       stream_v;
    logic                                       stream_last;
    logic [hdc_pkg::STREAM_W-1:0]               stream_d;

    row_t                        rows [NROWS];
    // reference vote per dimension
    int                          votes [hdc_pkg::DIM];
    logic [31:0]                 lfsr;
    // shift and key as last written
    logic [hdc_pkg::SHIFT_W-1:0] cur_shift;
    logic [hdc_pkg::DIM-1:0]     cur_key;
    int                          val_errs;
    int                          other_errs;

    hdc_bundle_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .item_v      (item_v),
        .item_hv     (item_hv),
        .stream_v    (stream_v),
        .stream_last (stream_last),
        .stream_d    (stream_d)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [hdc_pkg::APB_DW-1:0] exp,
                              input logic [hdc_pkg::APB_DW-1:0] act);
        if (act !== exp) begin
            $display("ERR %s exp=%h got=%h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_beat(input string name, input logic [hdc_pkg::STREAM_W-1:0] exp,
                              input logic [hdc_pkg::STREAM_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s exp=%h got=%h", name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s exp=%h got=%h", name, exp, act);
            val_errs++;
        end
    endtask

    // galois form, taps x^32+x^22+x^2+x+1, one step per bit
    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    // bit i goes to (i+shift) mod DIM, then xor with key
    function automatic logic [hdc_pkg::DIM-1:0] bind_ref(input logic [hdc_pkg::DIM-1:0] item,
                                                       input logic [hdc_pkg::SHIFT_W-1:0] sh,
                                                       input logic [hdc_pkg::DIM-1:0] k);
        logic [hdc_pkg::DIM-1:0] r;
        for (int i = 0; i < hdc_pkg::DIM; i++) begin
            r[(i + sh) % hdc_pkg::DIM] = item[i];
        end
        return r ^ k;
    endfunction

    // +1 for a one, -1 for a zero
    task automatic vote(input logic [hdc_pkg::DIM-1:0] v);
        for (int j = 0; j < hdc_pkg::DIM; j++) begin
            votes[j] += v[j] ? 1 : -1;
        end
    endtask

    // strictly positive count only, ties give 0
    function automatic logic [hdc_pkg::DIM-1:0] sign_ref();
        logic [hdc_pkg::DIM-1:0] s;
        for (int j = 0; j < hdc_pkg::DIM; j++) begin
            s[j] = (votes[j] > 0);
        end
        return s;
    endfunction

    task automatic clear_model();
        for (int j = 0; j < hdc_pkg::DIM; j++) begin
            votes[j] = 0;
        end
    endtask

    // entered just after a posedge, returns just after the completing edge
    task automatic apb_write(input logic [hdc_pkg::APB_AW-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic err;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        // access phase, sampled mid-cycle
        @(negedge clk);
        err = pslverr;
        // no wait states expected
        check_bit("pready", 1'b1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        if (err !== exp_err) begin
            $display("apb write at address %h returned pslverr %b, expected %b",
                     addr, err, exp_err);
            other_errs++;
        end
    endtask

    task automatic apb_read(input logic [hdc_pkg::APB_AW-1:0] addr, output logic [31:0] data,
                            input logic exp_err);
        logic err;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err  = pslverr;
        data = prdata;
        check_bit("pready", 1'b1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        if (err !== exp_err) begin
            $display("apb read at address %h returned pslverr %b, expected %b",
                     addr, err, exp_err);
            other_errs++;
        end
    endtask

    // one random item per core and cycle, masked cores vote in the model
    task automatic present_items(input int cycles, input logic [hdc_pkg::CORE_NUM-1:0] mask);
        logic [hdc_pkg::DIM-1:0]                   item;
        logic [hdc_pkg::CORE_NUM*hdc_pkg::DIM-1:0] hv;
        for (int n = 0; n < cycles; n++) begin
            for (int c = 0; c < hdc_pkg::CORE_NUM; c++) begin
                for (int b = 0; b < hdc_pkg::DIM; b++) begin
                    item[b] = lfsr_bit();
                end
                hv[c*hdc_pkg::DIM +: hdc_pkg::DIM] = item;
                if (mask[c]) begin
                    vote(bind_ref(item, cur_shift, cur_key));
                end
            end
            item_hv <= hv;
            item_v  <= mask;
            @(posedge clk);
        end
        item_v <= '0;
    endtask

    // called right after the completing start write
    task automatic collect_stream(input logic [hdc_pkg::DIM-1:0] exp_vec);
        int   lat;
        int   nbeat;
        logic seen;
        lat  = 0;
        seen = 1'b0;
        while (!seen && lat < TIMEOUT) begin
            @(negedge clk);
            lat++;
            seen = stream_v;
        end
        if (!seen) begin
            $display("timeout: stream_v never rose after a start write");
            other_errs++;
        end else begin
            // first beat two edges after the write
            check_word("stream_latency", 32'd2, lat);
            nbeat = 0;
            while (stream_v && nbeat < TIMEOUT) begin
                if (nbeat < hdc_pkg::BEATS) begin
                    check_beat("stream_d",
                               exp_vec[nbeat*hdc_pkg::STREAM_W +: hdc_pkg::STREAM_W], stream_d);
                end
                check_bit("stream_last", nbeat == hdc_pkg::BEATS - 1, stream_last);
                nbeat++;
                @(negedge clk);
            end
            if (stream_v) begin
                $display("timeout: stream_v stayed high");
                other_errs++;
            end
            check_word("beat_count", hdc_pkg::BEATS, nbeat);
        end
        @(posedge clk);
    endtask

    // stream must stay quiet over a whole start latency plus stream length
    task automatic confirm_no_stream(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            check_bit("stream_v", 1'b0, stream_v);
        end
        @(posedge clk);
    endtask

    task automatic fill_table();
        // shift, key, item cycles, core mask, clear first, expected sample count
        rows[0] = {6'd0,  64'h0000_0000_0000_0000, 8'd1, 4'b0001, 1'b1, 16'd1};
        rows[1] = {6'd5,  64'h0123_4567_89ab_cdef, 8'd1, 4'b0010, 1'b1, 16'd1};
        rows[2] = {6'd63, 64'hffff_0000_a5a5_c3c3, 8'd1, 4'b1000, 1'b1, 16'd1};
        // even vote totals, ties land on 0
        rows[3] = {6'd17, 64'h5555_aaaa_0f0f_f0f0, 8'd3, 4'b1111, 1'b1, 16'd12};
        rows[4] = {6'd33, 64'h8000_0000_0000_0001, 8'd2, 4'b0101, 1'b0, 16'd16};
        rows[5] = {6'd1,  64'h0000_0000_0000_0000, 8'd5, 4'b0111, 1'b1, 16'd15};
        rows[6] = {6'd40, 64'hc0de_1234_beef_5678, 8'd4, 4'b1011, 1'b0, 16'd27};
    endtask

    initial begin
        logic [31:0]             rd;
        logic [hdc_pkg::DIM-1:0] snap;
        val_errs   = 0;
        other_errs = 0;
        lfsr       = 32'h1fd9;
        cur_shift  = '0;
        cur_key    = '0;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        item_v     = '0;
        item_hv    = '0;
        clear_model();
        fill_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // idle after reset
        check_bit("stream_v", 1'b0, stream_v);
        check_bit("pslverr", 1'b0, pslverr);
        apb_read(hdc_pkg::ADDR_STATUS, rd, 1'b0);
        check_word("status", 32'h0, rd);

        // register readback, ctrl reads zero, hole gives an error
        apb_write(hdc_pkg::ADDR_SHIFT, 32'h2a, 1'b0);
        apb_read(hdc_pkg::ADDR_SHIFT, rd, 1'b0);
        check_word("shift", 32'h2a, rd);
        apb_write(hdc_pkg::ADDR_KEY0, 32'h9e37_79b9, 1'b0);
        apb_read(hdc_pkg::ADDR_KEY0, rd, 1'b0);
        check_word("key0", 32'h9e37_79b9, rd);
        apb_write(hdc_pkg::ADDR_KEY1, 32'h1357_9bdf, 1'b0);
        apb_read(hdc_pkg::ADDR_KEY1, rd, 1'b0);
        check_word("key1", 32'h1357_9bdf, rd);
        apb_read(hdc_pkg::ADDR_CTRL, rd, 1'b0);
        check_word("ctrl", 32'h0, rd);
        apb_write(ADDR_HOLE, 32'hffff_ffff, 1'b1);
        apb_read(ADDR_HOLE, rd, 1'b1);
        check_word("hole", 32'h0, rd);
        apb_read(hdc_pkg::ADDR_SHIFT, rd, 1'b0);
        check_word("shift", 32'h2a, rd);

        // binding and bundling rows
        for (int r = 0; r < NROWS; r++) begin
            apb_write(hdc_pkg::ADDR_SHIFT, rows[r].shift, 1'b0);
            apb_write(hdc_pkg::ADDR_KEY0, rows[r].key[31:0], 1'b0);
            apb_write(hdc_pkg::ADDR_KEY1, rows[r].key[63:32], 1'b0);
            cur_shift = rows[r].shift;
            cur_key   = rows[r].key;
            apb_read(hdc_pkg::ADDR_KEY1, rd, 1'b0);
            check_word("key1", rows[r].key[63:32], rd);
            if (rows[r].clr) begin
                apb_write(hdc_pkg::ADDR_CTRL, 1 << hdc_pkg::CTRL_CLEAR_BIT, 1'b0);
                clear_model();
            end
            present_items(rows[r].cycles, rows[r].mask);
            apb_read(hdc_pkg::ADDR_STATUS, rd, 1'b0);
            check_word("status", {rows[r].count, 16'h0}, rd);
            apb_write(hdc_pkg::ADDR_CTRL, 1 << hdc_pkg::CTRL_START_BIT, 1'b0);
            collect_stream(sign_ref());
        end

        // items during a stream stay out of the snapshot
        snap = sign_ref();
        apb_write(hdc_pkg::ADDR_CTRL, 1 << hdc_pkg::CTRL_START_BIT, 1'b0);
        fork
            collect_stream(snap);
            present_items(2, 4'b1111);
            // back-to-back start lands while the last beat is out
            apb_write(hdc_pkg::ADDR_CTRL, 1 << hdc_pkg::CTRL_START_BIT, 1'b0);
        join
        // dropped start leaves no stream behind
        confirm_no_stream(hdc_pkg::BEATS + 2);

        // busy reads 1 while the new items stream out
        apb_write(hdc_pkg::ADDR_CTRL, 1 << hdc_pkg::CTRL_START_BIT, 1'b0);
        fork
            collect_stream(sign_ref());
            begin
                apb_read(hdc_pkg::ADDR_STATUS, rd, 1'b0);
                check_bit("status_busy", 1'b1, rd[hdc_pkg::STATUS_BUSY_BIT]);
            end
        join

        // clear empties counters and sample count
        apb_write(hdc_pkg::ADDR_CTRL, 1 << hdc_pkg::CTRL_CLEAR_BIT, 1'b0);
        clear_model();
        apb_write(hdc_pkg::ADDR_CTRL, 1 << hdc_pkg::CTRL_START_BIT, 1'b0);
        collect_stream('0);
        apb_read(hdc_pkg::ADDR_STATUS, rd, 1'b0);
        check_word("status", 32'h0, rd);

        $display("checks done: %0d value errors, %0d other errors", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [hdc_pkg::APB_AW-1:0]        paddr,
    input  logic [hdc_pkg::APB_DW-1:0]        pwdata,
    input  logic [hdc_pkg::CORE_NUM-1:0]      store,
    input  logic                              busy,
    output logic [hdc_pkg::APB_DW-1:0]        prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic [hdc_pkg::SHIFT_W-1:0]       shift,
    output logic [hdc_pkg::DIM-1:0]           key,
    output logic                              start_pulse,
    output logic                              clear_pulse
);

    logic                              access;
    logic                              wr_en;
    logic                              addr_hit;
    logic [hdc_pkg::SAMPLE_CNT_W-1:0]  sample_cnt;
    // stores seen this cycle
    logic [hdc_pkg::SAMPLE_CNT_W-1:0]  store_cnt;
    logic [hdc_pkg::APB_DW-1:0]        status;

    // no wait states
    assign pready = 1'b1;

    // access phase completes on this edge
    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    always_comb begin
        case (paddr)
            hdc_pkg::ADDR_CTRL,
            hdc_pkg::ADDR_STATUS,
            hdc_pkg::ADDR_SHIFT,
            hdc_pkg::ADDR_KEY0,
            hdc_pkg::ADDR_KEY1: addr_hit = 1'b1;
            default:            addr_hit = 1'b0;
        endcase
    end

    // error only in the access phase
    assign pslverr = access && !addr_hit;

    // shift and key
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift <= '0;
            key   <= '0;
        end else if (wr_en) begin
            if (paddr == hdc_pkg::ADDR_SHIFT) begin
                shift <= pwdata[hdc_pkg::SHIFT_W-1:0];
            end
            if (paddr == hdc_pkg::ADDR_KEY0) begin
                key[31:0] <= pwdata;
            end
            if (paddr == hdc_pkg::ADDR_KEY1) begin
                key[63:32] <= pwdata;
            end
        end
    end

    // ctrl writes become one-cycle pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_pulse <= 1'b0;
            clear_pulse <= 1'b0;
        end else begin
            start_pulse <= wr_en && (paddr == hdc_pkg::ADDR_CTRL)
                           && pwdata[hdc_pkg::CTRL_START_BIT];
            clear_pulse <= wr_en && (paddr == hdc_pkg::ADDR_CTRL)
                           && pwdata[hdc_pkg::CTRL_CLEAR_BIT];
        end
    end

    // popcount of store
    always_comb begin
        store_cnt = '0;
        for (int c = 0; c < hdc_pkg::CORE_NUM; c++) begin
            if (store[c]) begin
                store_cnt = store_cnt + 1'b1;
            end
        end
    end

    // accepted samples, wraps, cleared together with the counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_cnt <= '0;
        end else if (clear_pulse) begin
            sample_cnt <= '0;
        end else begin
            sample_cnt <= sample_cnt + store_cnt;
        end
    end

    always_comb begin
        status = '0;
        status[hdc_pkg::STATUS_BUSY_BIT] = busy;
        status[hdc_pkg::STATUS_CNT_LSB +: hdc_pkg::SAMPLE_CNT_W] = sample_cnt;
    end

    // read mux, ctrl and holes read zero
    always_comb begin
        prdata = '0;
        case (paddr)
            hdc_pkg::ADDR_STATUS: prdata = status;
            hdc_pkg::ADDR_SHIFT:  prdata[hdc_pkg::SHIFT_W-1:0] = shift;
            hdc_pkg::ADDR_KEY0:   prdata = key[31:0];
            hdc_pkg::ADDR_KEY1:   prdata = key[63:32];
            default:              prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/bind_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module bind_core (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          item_v,
    input  logic [hdc_pkg::DIM-1:0]       item_hv,
    input  logic [hdc_pkg::SHIFT_W-1:0]   shift,
    input  logic [hdc_pkg::DIM-1:0]       key,
    output logic                          store,
    output logic [hdc_pkg::DIM-1:0]       bound_hv
);

    // item placed twice so a plain shift yields the rotation
    logic [2*hdc_pkg::DIM-1:0] doubled;
    logic [hdc_pkg::DIM-1:0]   rotated;

    // bit i lands at (i+shift) mod DIM in the upper half
    always_comb begin
        doubled = {item_hv, item_hv} << shift;
        rotated = doubled[2*hdc_pkg::DIM-1:hdc_pkg::DIM];
    end

    // one store pulse per accepted item
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store <= 1'b0;
        end else begin
            store <= item_v;
        end
    end

    // bound vector, payload only
    always_ff @(posedge clk) begin
        if (item_v) begin
            // permute then bind with the key
            bound_hv <= rotated ^ key;
        end
    end

endmodule

`default_nettype wire

// ==== src/bundle_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bundle_buffer (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       clear,
    input  logic                                       start,
    input  logic [hdc_pkg::CORE_NUM-1:0]               store,
    input  logic [hdc_pkg::CORE_NUM*hdc_pkg::DIM-1:0]  bound_hv,
    output logic                                       busy,
    output logic                                       stream_v,
    output logic                                       stream_last,
    output logic [hdc_pkg::STREAM_W-1:0]               stream_d
);

    // live sign vector from the counters
    logic [hdc_pkg::DIM-1:0]      sign_vec;
    // frozen copy that is streamed out
    logic [hdc_pkg::DIM-1:0]      shadow;
    logic [hdc_pkg::BEAT_W-1:0]   beat;

    // one counter per dimension
    for (genvar j = 0; j < hdc_pkg::DIM; j++) begin : g_dim
        // bit j of every core, core 0 lowest
        logic [hdc_pkg::CORE_NUM-1:0] col;

        for (genvar c = 0; c < hdc_pkg::CORE_NUM; c++) begin : g_core
            assign col[c] = bound_hv[c*hdc_pkg::DIM + j];
        end

        dim_counter u_cnt (
            .clk      (clk),
            .rst_n    (rst_n),
            .clear    (clear),
            .store    (store),
            .core_bit (col),
            .sign_bit (sign_vec[j])
        );
    end

    // readout sequencer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            beat <= '0;
        end else if (!busy) begin
            // start during a stream is dropped here
            if (start) begin
                busy <= 1'b1;
                beat <= '0;
            end
        end else if (beat == hdc_pkg::BEAT_W'(hdc_pkg::BEATS - 1)) begin
            // last beat leaves with this edge
            busy <= 1'b0;
        end else begin
            beat <= beat + 1'b1;
        end
    end

    // snapshot, data only
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            shadow <= sign_vec;
        end
    end

    // one beat per cycle while busy, low slice first
    assign stream_v    = busy;
    assign stream_last = busy && (beat == hdc_pkg::BEAT_W'(hdc_pkg::BEATS - 1));
    assign stream_d    = shadow[beat*hdc_pkg::STREAM_W +: hdc_pkg::STREAM_W];

endmodule

`default_nettype wire

// ==== src/dim_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module dim_counter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clear,
    input  logic [hdc_pkg::CORE_NUM-1:0]  store,
    input  logic [hdc_pkg::CORE_NUM-1:0]  core_bit,
    output logic                          sign_bit
);

    logic signed [hdc_pkg::CNT_W-1:0] count;
    logic signed [hdc_pkg::CNT_W-1:0] count_nxt;
    // one guard bit so a step past the limit is still visible
    logic signed [hdc_pkg::CNT_W:0]   sum;

    always_comb begin
        sum = {count[hdc_pkg::CNT_W-1], count};
        // +1 for a one, -1 for a zero, only from storing cores
        for (int c = 0; c < hdc_pkg::CORE_NUM; c++) begin
            if (store[c]) begin
                if (core_bit[c]) begin
                    sum = sum + 1'b1;
                end else begin
                    sum = sum - 1'b1;
                end
            end
        end
        // clamp both ways to the same magnitude
        if (sum > hdc_pkg::CNT_MAX) begin
            count_nxt = hdc_pkg::CNT_MAX;
        end else if (sum < -hdc_pkg::CNT_MAX) begin
            count_nxt = -hdc_pkg::CNT_MAX;
        end else begin
            count_nxt = sum[hdc_pkg::CNT_W-1:0];
        end
    end

    // clear wins over votes arriving in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else begin
            count <= count_nxt;
        end
    end

    // tie or negative gives 0
    assign sign_bit = (count > 0);

endmodule

`default_nettype wire

// ==== src/hdc_bundle_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hdc_bundle_top (
    input  logic                                       clk,
    input  logic                                       rst_n,
    // apb host side
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [hdc_pkg::APB_AW-1:0]                 paddr,
    input  logic [hdc_pkg::APB_DW-1:0]                 pwdata,
    output logic [hdc_pkg::APB_DW-1:0]                 prdata,
    output logic                                       pready,
    output logic                                       pslverr,
    // ready-made item vectors, core i in slice i
    input  logic [hdc_pkg::CORE_NUM-1:0]               item_v,
    input  logic [hdc_pkg::CORE_NUM*hdc_pkg::DIM-1:0]  item_hv,
    // sign vector readout
    output logic                                       stream_v,
    output logic                                       stream_last,
    output logic [hdc_pkg::STREAM_W-1:0]               stream_d
);

    logic [hdc_pkg::SHIFT_W-1:0]                shift;
    logic [hdc_pkg::DIM-1:0]                    key;
    logic                                       start_pulse;
    logic                                       clear_pulse;
    logic                                       busy;
    // one store bit per core
    logic [hdc_pkg::CORE_NUM-1:0]               store;
    logic [hdc_pkg::CORE_NUM*hdc_pkg::DIM-1:0]  bound_hv;

    // host registers
    apb_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .store       (store),
        .busy        (busy),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .shift       (shift),
        .key         (key),
        .start_pulse (start_pulse),
        .clear_pulse (clear_pulse)
    );

    // shared shift and key for all cores
    for (genvar i = 0; i < hdc_pkg::CORE_NUM; i++) begin : g_core
        bind_core u_core (
            .clk      (clk),
            .rst_n    (rst_n),
            .item_v   (item_v[i]),
            .item_hv  (item_hv[i*hdc_pkg::DIM +: hdc_pkg::DIM]),
            .shift    (shift),
            .key      (key),
            .store    (store[i]),
            .bound_hv (bound_hv[i*hdc_pkg::DIM +: hdc_pkg::DIM])
        );
    end

    // counters and stream
    bundle_buffer u_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (clear_pulse),
        .start       (start_pulse),
        .store       (store),
        .bound_hv    (bound_hv),
        .busy        (busy),
        .stream_v    (stream_v),
        .stream_last (stream_last),
        .stream_d    (stream_d)
    );

endmodule

`default_nettype wire

// ==== src/hdc_pkg.sv ====
`default_nettype none

package hdc_pkg;

    // hypervector geometry
    localparam int DIM      = 64;
    localparam int CORE_NUM = 4;

    // vote counters, signed two's complement
    localparam int CNT_W = 12;
    // symmetric limit, one short of the negative range end
    localparam logic signed [CNT_W-1:0] CNT_MAX = 2047;

    // readout stream
    localparam int STREAM_W = 32;
    localparam int BEATS    = DIM / STREAM_W;
    // beat index width, at least one bit
    localparam int BEAT_W   = (BEATS > 1) ? $clog2(BEATS) : 1;

    // rotate amount covers 0..DIM-1
    localparam int SHIFT_W      = 6;
    localparam int SAMPLE_CNT_W = 16;

    // apb bus
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // register map
    localparam logic [APB_AW-1:0] ADDR_CTRL   = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_SHIFT  = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_KEY0   = 8'h0c;
    localparam logic [APB_AW-1:0] ADDR_KEY1   = 8'h10;

    // ctrl fields, write-one pulses
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_CLEAR_BIT = 1;

    // status fields
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_CNT_LSB  = 16;

endpackage

`default_nettype wire
